// ==== verilog/eth_pkg.sv ====
package eth_pkg;

    // GMII framing bytes
    localparam logic [7:0]  PREAMBLE_BYTE   = 8'h55;
    localparam logic [7:0]  SFD_BYTE        = 8'hd5;

    localparam logic [15:0] ETH_TYPE_ARP    = 16'h0806;
    localparam logic [47:0] BCAST_MAC       = 48'hffff_ffff_ffff;

    localparam logic [31:0] CRC_POLY        = 32'h04c1_1db7;   // ieee 802.3, normal form

    // 42 bytes of header and arp payload, padded up to 60
    localparam int          MIN_PAYLOAD_PAD = 18;

endpackage

// ==== verilog/arp_pkg.sv ====
package arp_pkg;

    localparam logic [15:0] HW_TYPE_ETH     = 16'h0001;
    localparam logic [15:0] PROTO_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  MAC_LEN         = 8'd6;
    localparam logic [7:0]  IP_LEN          = 8'd4;

    typedef enum logic [15:0] {
        ARP_OP_REQ = 16'd1,
        ARP_OP_REP = 16'd2
    } arp_op_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_WAIT,        // waiting for the arbiter grant
        TX_PREAMBLE,
        TX_ETH_HEAD,
        TX_ARP_HEAD,
        TX_DATA,
        TX_PAD,
        TX_CRC
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_HEADER,
        RX_PAYLOAD,
        RX_DROP         // rest of a frame we do not care about
    } rx_state_e;

endpackage

// ==== verilog/arp_rx_parser.sv ====
module arp_rx_parser #(
    parameter logic [47:0] BOARD_MAC = 48'h12_34_56_78_9a_bc,
    parameter logic [31:0] BOARD_IP  = 32'hc0_a8_01_0a
) (
    input  logic        gmii_tx_clk,
    input  logic        rstn,
    input  logic [7:0]  gmii_rxd,
    input  logic        gmii_rx_dv,
    output logic [47:0] dec_mac,
    output logic [31:0] dec_ip,
    output logic        refresh
);

    arp_pkg::rx_state_e rx_state;
    logic [5:0]         byte_cnt;   // bytes after sfd, saturates at 42
    logic [47:0]        dst_sr;
    logic [7:0]         type_hi;
    logic [15:0]        op_sr;
    logic [47:0]        sha_sr;
    logic [31:0]        spa_sr;
    logic [31:0]        tpa_sr;
    logic               dst_ok;
    logic               type_ok;
    logic               hit;

    assign dst_ok  = (dst_sr == eth_pkg::BCAST_MAC) || (dst_sr == BOARD_MAC);
    assign type_ok = ({type_hi, gmii_rxd} == eth_pkg::ETH_TYPE_ARP);   // valid at byte 13
    assign hit     = (byte_cnt == 6'd42) && (op_sr == arp_pkg::ARP_OP_REQ)
                     && (tpa_sr == BOARD_IP);

    always_ff @(posedge gmii_tx_clk or negedge rstn) begin
        if (!rstn) begin
            rx_state <= arp_pkg::RX_IDLE;
            byte_cnt <= 6'd0;
            refresh  <= 1'b0;
        end else begin
            refresh <= 1'b0;
            case (rx_state)
                arp_pkg::RX_IDLE: begin
                    if (gmii_rx_dv) begin
                        rx_state <= (gmii_rxd == eth_pkg::PREAMBLE_BYTE) ?
                                    arp_pkg::RX_PREAMBLE : arp_pkg::RX_DROP;
                    end
                end
                arp_pkg::RX_PREAMBLE: begin
                    byte_cnt <= 6'd0;
                    if (!gmii_rx_dv) begin
                        rx_state <= arp_pkg::RX_IDLE;
                    end else if (gmii_rxd == eth_pkg::SFD_BYTE) begin
                        rx_state <= arp_pkg::RX_HEADER;
                    end else if (gmii_rxd != eth_pkg::PREAMBLE_BYTE) begin
                        rx_state <= arp_pkg::RX_DROP;
                    end
                end
                arp_pkg::RX_HEADER: begin
                    byte_cnt <= byte_cnt + 6'd1;
                    if (!gmii_rx_dv) begin
                        rx_state <= arp_pkg::RX_IDLE;
                    end else if (byte_cnt == 6'd13) begin
                        rx_state <= (dst_ok && type_ok) ? arp_pkg::RX_PAYLOAD : arp_pkg::RX_DROP;
                    end
                end
                arp_pkg::RX_PAYLOAD: begin
                    if (!gmii_rx_dv) begin
                        rx_state <= arp_pkg::RX_IDLE;
                        refresh  <= hit;    // one cycle after dv falls
                    end else if (byte_cnt != 6'd42) begin
                        byte_cnt <= byte_cnt + 6'd1;
                    end
                end
                default: begin
                    if (!gmii_rx_dv) begin
                        rx_state <= arp_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end

    // field capture by byte position, arp payload starts at byte 14
    always_ff @(posedge gmii_tx_clk) begin
        if (gmii_rx_dv && rx_state == arp_pkg::RX_HEADER) begin
            if (byte_cnt < 6'd6) begin
                dst_sr <= {dst_sr[39:0], gmii_rxd};
            end
            if (byte_cnt == 6'd12) begin
                type_hi <= gmii_rxd;
            end
        end
        if (gmii_rx_dv && rx_state == arp_pkg::RX_PAYLOAD) begin
            if (byte_cnt inside {[6'd20:6'd21]}) begin
                op_sr <= {op_sr[7:0], gmii_rxd};
            end
            if (byte_cnt inside {[6'd22:6'd27]}) begin
                sha_sr <= {sha_sr[39:0], gmii_rxd};
            end
            if (byte_cnt inside {[6'd28:6'd31]}) begin
                spa_sr <= {spa_sr[23:0], gmii_rxd};
            end
            if (byte_cnt inside {[6'd38:6'd41]}) begin
                tpa_sr <= {tpa_sr[23:0], gmii_rxd};
            end
        end
    end

    always_ff @(posedge gmii_tx_clk) begin
        if (rx_state == arp_pkg::RX_PAYLOAD && !gmii_rx_dv && hit) begin
            dec_mac <= sha_sr;
            dec_ip  <= spa_sr;
        end
    end

endmodule

// ==== verilog/crc32_d8.sv ====
module crc32_d8 (
    input  logic        gmii_tx_clk,
    input  logic        rstn,
    input  logic [7:0]  data,
    input  logic        crc_en,
    input  logic        crc_clr,
    output logic [31:0] crc_data,
    output logic [7:0]  crc_next
);

    logic [31:0] crc_upd;

    // msb-first register, data bits fed lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[31] ^ d[i]) begin
                r = {r[30:0], 1'b0} ^ eth_pkg::CRC_POLY;
            end else begin
                r = {r[30:0], 1'b0};
            end
        end
        return r;
    endfunction

    assign crc_upd  = crc_step(crc_data, data);
    assign crc_next = crc_upd[31:24];  // ends up as the low fcs byte once reversed

    always_ff @(posedge gmii_tx_clk or negedge rstn) begin
        if (!rstn) begin
            crc_data <= 32'hffff_ffff;
        end else if (crc_clr) begin
            crc_data <= 32'hffff_ffff;
        end else if (crc_en) begin
            crc_data <= crc_upd;
        end
    end

endmodule

// ==== verilog/arp_tx.sv ====
module arp_tx #(
    parameter logic [47:0] BOARD_MAC = 48'h12_34_56_78_9a_bc,
    parameter logic [31:0] BOARD_IP  = 32'hc0_a8_01_0a
) (
    input  logic        rstn,
    input  logic        gmii_tx_clk,
    input  logic [47:0] dec_mac,
    input  logic [31:0] dec_ip,
    input  logic        refresh,
    input  logic [31:0] crc_data,
    input  logic [7:0]  crc_next,
    input  logic        arp_tx_sel,
    output logic        gmii_tx_en,
    output logic [7:0]  gmii_txd,
    output logic        crc_en,
    output logic        crc_clr,
    output logic        arp_tx_req,
    output logic        arp_tx_done,
    output logic        arp_working
);

    localparam logic [111:0] ETH_HEAD = {eth_pkg::BCAST_MAC, BOARD_MAC, eth_pkg::ETH_TYPE_ARP};
    localparam logic [63:0]  ARP_HEAD = {arp_pkg::HW_TYPE_ETH, arp_pkg::PROTO_TYPE_IPV4,
                                         arp_pkg::MAC_LEN, arp_pkg::IP_LEN,
                                         16'(arp_pkg::ARP_OP_REP)};

    arp_pkg::tx_state_e cur_state;
    arp_pkg::tx_state_e next_state;
    logic               skip_en;    // current section done, advance
    logic [4:0]         cnt;
    logic [4:0]         last_cnt;
    logic [7:0]         tx_byte;
    logic               tx_done_t;
    logic               take;
    logic [159:0]       arp_data;   // sender mac, sender ip, target mac, target ip

    function automatic logic [7:0] fcs_byte(input logic [7:0] c);
        for (int i = 0; i < 8; i++) begin
            fcs_byte[i] = ~c[7 - i];
        end
    endfunction

    assign take = refresh && (cur_state == arp_pkg::TX_IDLE);  // busy frames ignore refresh

    always_ff @(posedge gmii_tx_clk) begin
        if (take) begin
            arp_data <= {BOARD_MAC, BOARD_IP, dec_mac, dec_ip};
        end
    end

    always_ff @(posedge gmii_tx_clk or negedge rstn) begin
        if (!rstn) begin
            cur_state <= arp_pkg::TX_IDLE;
        end else begin
            cur_state <= next_state;
        end
    end

    always_comb begin
        next_state = cur_state;
        if (skip_en) begin
            case (cur_state)
                arp_pkg::TX_IDLE:     next_state = arp_pkg::TX_WAIT;
                arp_pkg::TX_WAIT:     next_state = arp_pkg::TX_PREAMBLE;
                arp_pkg::TX_PREAMBLE: next_state = arp_pkg::TX_ETH_HEAD;
                arp_pkg::TX_ETH_HEAD: next_state = arp_pkg::TX_ARP_HEAD;
                arp_pkg::TX_ARP_HEAD: next_state = arp_pkg::TX_DATA;
                arp_pkg::TX_DATA:     next_state = arp_pkg::TX_PAD;
                arp_pkg::TX_PAD:      next_state = arp_pkg::TX_CRC;
                default:              next_state = arp_pkg::TX_IDLE;
            endcase
        end
    end

    // byte to send next and the last count of each section
    always_comb begin
        last_cnt = 5'd0;
        tx_byte  = 8'h00;
        case (next_state)
            arp_pkg::TX_PREAMBLE: begin
                last_cnt = 5'd7;
                tx_byte  = (cnt == 5'd7) ? eth_pkg::SFD_BYTE : eth_pkg::PREAMBLE_BYTE;
            end
            arp_pkg::TX_ETH_HEAD: begin
                last_cnt = 5'd13;
                tx_byte  = ETH_HEAD[8 * (13 - cnt) +: 8];
            end
            arp_pkg::TX_ARP_HEAD: begin
                last_cnt = 5'd7;
                tx_byte  = ARP_HEAD[8 * (7 - cnt) +: 8];
            end
            arp_pkg::TX_DATA: begin
                last_cnt = 5'd19;
                tx_byte  = arp_data[8 * (19 - cnt) +: 8];
            end
            arp_pkg::TX_PAD: begin
                last_cnt = 5'(eth_pkg::MIN_PAYLOAD_PAD - 1);
            end
            arp_pkg::TX_CRC: begin
                last_cnt = 5'd3;
                case (cnt[1:0])
                    2'd0:    tx_byte = fcs_byte(crc_next);   // last pad byte still folding in
                    2'd1:    tx_byte = fcs_byte(crc_data[23:16]);
                    2'd2:    tx_byte = fcs_byte(crc_data[15:8]);
                    default: tx_byte = fcs_byte(crc_data[7:0]);
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge gmii_tx_clk or negedge rstn) begin
        if (!rstn) begin
            skip_en     <= 1'b0;
            cnt         <= 5'd0;
            gmii_tx_en  <= 1'b0;
            gmii_txd    <= 8'h00;
            crc_en      <= 1'b0;
            tx_done_t   <= 1'b0;
            arp_tx_req  <= 1'b0;
            arp_working <= 1'b0;
        end else begin
            skip_en    <= 1'b0;
            gmii_tx_en <= !(next_state inside {arp_pkg::TX_IDLE, arp_pkg::TX_WAIT});
            gmii_txd   <= tx_byte;
            crc_en     <= next_state inside {arp_pkg::TX_ETH_HEAD, arp_pkg::TX_ARP_HEAD,
                                             arp_pkg::TX_DATA, arp_pkg::TX_PAD};
            tx_done_t  <= (next_state == arp_pkg::TX_CRC) && (cnt == last_cnt);
            if (next_state == arp_pkg::TX_IDLE) begin
                arp_working <= 1'b0;
                skip_en     <= take;
            end else if (next_state == arp_pkg::TX_WAIT) begin
                arp_tx_req  <= !arp_tx_sel;     // held until the grant shows up
                arp_working <= arp_tx_sel;
                skip_en     <= arp_tx_sel;
            end else if (cnt == last_cnt) begin
                skip_en <= 1'b1;
                cnt     <= 5'd0;
            end else begin
                cnt <= cnt + 5'd1;
            end
        end
    end

    always_ff @(posedge gmii_tx_clk or negedge rstn) begin
        if (!rstn) begin
            arp_tx_done <= 1'b0;
            crc_clr     <= 1'b0;
        end else begin
            arp_tx_done <= tx_done_t;
            crc_clr     <= tx_done_t;   // preset crc for the next frame
        end
    end

endmodule

// ==== verilog/gmii_tx_arbiter.sv ====
module gmii_tx_arbiter (
    input  logic       gmii_tx_clk,
    input  logic       rstn,
    input  logic       arp_tx_req,
    input  logic       arp_tx_done,
    input  logic       arp_tx_en,
    input  logic [7:0] arp_txd,
    input  logic       user_tx_req,
    input  logic       user_tx_en,
    input  logic [7:0] user_txd,
    output logic       arp_tx_sel,
    output logic       user_tx_sel,
    output logic       gmii_tx_en,
    output logic [7:0] gmii_txd
);

    typedef enum logic [1:0] {
        GNT_FREE,
        GNT_ARP,
        GNT_USER
    } grant_e;

    grant_e grant;

    always_ff @(posedge gmii_tx_clk or negedge rstn) begin
        if (!rstn) begin
            grant <= GNT_FREE;
        end else begin
            case (grant)
                GNT_FREE: begin
                    if (arp_tx_req) begin
                        grant <= GNT_ARP;      // arp first on a tie
                    end else if (user_tx_req) begin
                        grant <= GNT_USER;
                    end
                end
                GNT_ARP: begin
                    if (arp_tx_done) begin
                        grant <= GNT_FREE;
                    end
                end
                GNT_USER: begin
                    if (!user_tx_req) begin
                        grant <= GNT_FREE;     // no preemption by a waiting reply
                    end
                end
                default: grant <= GNT_FREE;
            endcase
        end
    end

    assign arp_tx_sel  = (grant == GNT_ARP);
    assign user_tx_sel = (grant == GNT_USER);

    always_ff @(posedge gmii_tx_clk or negedge rstn) begin
        if (!rstn) begin
            gmii_tx_en <= 1'b0;
            gmii_txd   <= 8'h00;
        end else begin
            gmii_tx_en <= (arp_tx_sel && arp_tx_en) || (user_tx_sel && user_tx_en);
            gmii_txd   <= arp_tx_sel ? arp_txd : (user_tx_sel ? user_txd : 8'h00);
        end
    end

endmodule

// ==== verilog/arp_responder.sv ====
module arp_responder #(
    parameter logic [47:0] BOARD_MAC = 48'h12_34_56_78_9a_bc,
    parameter logic [31:0] BOARD_IP  = 32'hc0_a8_01_0a
) (
    input  logic       gmii_tx_clk,
    input  logic       rstn,
    input  logic [7:0] gmii_rxd,        // already in the tx clock domain
    input  logic       gmii_rx_dv,
    input  logic       user_tx_req,
    input  logic       user_tx_en,
    input  logic [7:0] user_txd,
    output logic       gmii_tx_en,
    output logic [7:0] gmii_txd,
    output logic       user_tx_sel,
    output logic       arp_working
);

    logic [47:0] dec_mac;
    logic [31:0] dec_ip;
    logic        refresh;
    logic [31:0] crc_data;
    logic [7:0]  crc_next;
    logic        crc_en;
    logic        crc_clr;
    logic        arp_tx_en;
    logic [7:0]  arp_txd;
    logic        arp_tx_req;
    logic        arp_tx_sel;
    logic        arp_tx_done;

    arp_rx_parser #(
        .BOARD_MAC (BOARD_MAC),
        .BOARD_IP  (BOARD_IP)
    ) arp_rx_parser_i (
        .gmii_tx_clk (gmii_tx_clk),
        .rstn        (rstn),
        .gmii_rxd    (gmii_rxd),
        .gmii_rx_dv  (gmii_rx_dv),
        .dec_mac     (dec_mac),
        .dec_ip      (dec_ip),
        .refresh     (refresh)
    );

    arp_tx #(
        .BOARD_MAC (BOARD_MAC),
        .BOARD_IP  (BOARD_IP)
    ) arp_tx_i (
        .rstn        (rstn),
        .gmii_tx_clk (gmii_tx_clk),
        .dec_mac     (dec_mac),
        .dec_ip      (dec_ip),
        .refresh     (refresh),
        .crc_data    (crc_data),
        .crc_next    (crc_next),
        .arp_tx_sel  (arp_tx_sel),
        .gmii_tx_en  (arp_tx_en),
        .gmii_txd    (arp_txd),
        .crc_en      (crc_en),
        .crc_clr     (crc_clr),
        .arp_tx_req  (arp_tx_req),
        .arp_tx_done (arp_tx_done),
        .arp_working (arp_working)
    );

    crc32_d8 crc32_d8_i (
        .gmii_tx_clk (gmii_tx_clk),
        .rstn        (rstn),
        .data        (arp_txd),         // crc runs on the unregistered reply bytes
        .crc_en      (crc_en),
        .crc_clr     (crc_clr),
        .crc_data    (crc_data),
        .crc_next    (crc_next)
    );

    gmii_tx_arbiter gmii_tx_arbiter_i (
        .gmii_tx_clk (gmii_tx_clk),
        .rstn        (rstn),
        .arp_tx_req  (arp_tx_req),
        .arp_tx_done (arp_tx_done),
        .arp_tx_en   (arp_tx_en),
        .arp_txd     (arp_txd),
        .user_tx_req (user_tx_req),
        .user_tx_en  (user_tx_en),
        .user_txd    (user_txd),
        .arp_tx_sel  (arp_tx_sel),
        .user_tx_sel (user_tx_sel),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd)
    );

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic gmii_tx_clk,
    output logic rstn
);

    initial begin
        gmii_tx_clk = 1'b0;
        forever #(PERIOD / 2) gmii_tx_clk = ~gmii_tx_clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge gmii_tx_clk);
        #2 rstn = 1'b1;     // released with the other inputs
    end

endmodule

// ==== bench/arp_checker.sv ====
module arp_checker #(
    parameter logic [47:0] BOARD_MAC = 48'h0,
    parameter logic [31:0] BOARD_IP  = 32'h0,
    parameter int          USER_LEN  = 16
) (
    input  logic        gmii_tx_clk,
    input  logic        rstn,
    input  logic        gmii_tx_en,
    input  logic [7:0]  gmii_txd,
    input  logic        user_tx_sel,
    input  logic        arp_working,
    input  logic        idle_chk,
    input  logic        exp_push,
    input  logic        exp_kind,      // 0 reply, 1 user frame
    input  logic [47:0] exp_mac,
    input  logic [31:0] exp_ip,        // low byte is the user seed
    input  logic        done_chk,
    output int          frames_seen,
    output int          err_count
);

    logic [7:0]  burst[$];
    logic        kind_q[$];
    logic [47:0] mac_q[$];
    logic [31:0] ip_q[$];

    // reflected crc over destination through pad, bytes 8 to 67
    function automatic logic [31:0] eth_fcs(input logic [575:0] f);
        logic [31:0] rpoly;
        logic [31:0] c;
        for (int b = 0; b < 32; b++) begin
            rpoly[b] = eth_pkg::CRC_POLY[31 - b];
        end
        c = 32'hffff_ffff;
        for (int i = 8; i < 68; i++) begin
            c = c ^ {24'h0, f[8 * (71 - i) +: 8]};
            for (int j = 0; j < 8; j++) begin
                c = c[0] ? ((c >> 1) ^ rpoly) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic check_low(input string name, input logic val);
        if (val !== 1'b0) begin
            $display("CHECK FAILED t=%0t %s got %b expected 0", $time, name, val);
            err_count++;
        end
    endtask

    task automatic compare_burst();
        logic        kind;
        logic [47:0] mac;
        logic [31:0] ip;
        logic [575:0] f;
        logic [31:0] fcs;
        logic [7:0]  exp_b;
        int          n;
        frames_seen++;
        if (kind_q.size() == 0) begin
            $display("t=%0t unexpected frame of %0d bytes on gmii_txd", $time, burst.size());
            err_count++;
            return;
        end
        kind = kind_q.pop_front();
        mac  = mac_q.pop_front();
        ip   = ip_q.pop_front();
        f    = {{7{eth_pkg::PREAMBLE_BYTE}}, eth_pkg::SFD_BYTE, eth_pkg::BCAST_MAC, BOARD_MAC,
                eth_pkg::ETH_TYPE_ARP, arp_pkg::HW_TYPE_ETH, arp_pkg::PROTO_TYPE_IPV4,
                arp_pkg::MAC_LEN, arp_pkg::IP_LEN, 16'(arp_pkg::ARP_OP_REP),
                BOARD_MAC, BOARD_IP, mac, ip, {eth_pkg::MIN_PAYLOAD_PAD{8'h00}}, 32'h0};
        fcs     = eth_fcs(f);
        f[31:0] = {fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]};   // low byte first
        n       = kind ? USER_LEN : 72;
        if (burst.size() != n) begin
            $display("t=%0t frame is %0d bytes long, expected %0d", $time, burst.size(), n);
            err_count++;
        end
        for (int i = 0; i < n && i < burst.size(); i++) begin
            exp_b = kind ? 8'(ip[7:0] + i) : f[8 * (71 - i) +: 8];
            if (burst[i] !== exp_b) begin
                $display("CHECK FAILED t=%0t gmii_txd byte %0d got %02h expected %02h",
                         $time, i, burst[i], exp_b);
                err_count++;
            end
        end
    endtask

    initial begin
        frames_seen = 0;
        err_count   = 0;
    end

    always @(posedge gmii_tx_clk) begin
        if (exp_push) begin
            kind_q.push_back(exp_kind);
            mac_q.push_back(exp_mac);
            ip_q.push_back(exp_ip);
        end
        if (idle_chk) begin
            check_low("gmii_tx_en", gmii_tx_en);
            check_low("user_tx_sel", user_tx_sel);
            check_low("arp_working", arp_working);
        end
        if (!rstn) begin
            burst.delete();
        end else if (gmii_tx_en) begin
            burst.push_back(gmii_txd);
        end else if (burst.size() != 0) begin
            compare_burst();
            burst.delete();
        end
        if (done_chk && kind_q.size() != 0) begin
            $display("%0d expected frames were never transmitted", kind_q.size());
            err_count += kind_q.size();
        end
    end

endmodule

// ==== bench/arp_responder_asserts.sv ====
module arp_responder_asserts (
    input logic gmii_tx_clk,
    input logic rstn,
    input logic arp_tx_req,
    input logic arp_tx_sel,
    input logic arp_tx_done,
    input logic arp_tx_en
);

    tx_within_grant: assert property (@(posedge gmii_tx_clk) disable iff (!rstn)
        arp_tx_en |-> arp_tx_sel)
        else $error("arp_tx sending bytes without arp_tx_sel");

    done_pulse: assert property (@(posedge gmii_tx_clk) disable iff (!rstn)
        arp_tx_done |=> !arp_tx_done)
        else $error("arp_tx_done longer than one cycle");

    req_held: assert property (@(posedge gmii_tx_clk) disable iff (!rstn)
        (arp_tx_req && !arp_tx_sel) |=> arp_tx_req)
        else $error("arp_tx_req dropped before arp_tx_sel");

endmodule

// arp_tx strobes are visible on the arbiter ports
bind gmii_tx_arbiter arp_responder_asserts arp_responder_asserts_i (
    .gmii_tx_clk (gmii_tx_clk),
    .rstn        (rstn),
    .arp_tx_req  (arp_tx_req),
    .arp_tx_sel  (arp_tx_sel),
    .arp_tx_done (arp_tx_done),
    .arp_tx_en   (arp_tx_en)
);

// ==== bench/arp_responder_tb.sv ====
module arp_responder_tb;

    localparam logic [47:0] BOARD_MAC  = 48'h02_00_5e_10_20_30;
    localparam logic [31:0] BOARD_IP   = 32'hc0_a8_00_63;
    localparam int          N_ROWS     = 8;
    localparam int          USER_LEN   = 16;
    localparam int          ROW_CYCLES = 1000;     // worst frame, waits and gap
    localparam int          TIMEOUT    = (N_ROWS * ROW_CYCLES + 200) * 20;

    typedef struct packed {
        logic [47:0] sha;
        logic [31:0] spa;
        logic [31:0] tpa;
        logic [15:0] op;
        logic [15:0] etype;
        logic [47:0] dst;
        logic        reply;
        logic [1:0]  overlap;   // 0 none, 1 user holds port, 2 user asks with arp
    } row_t;

    logic        gmii_tx_clk;
    logic        rstn;
    logic [7:0]  gmii_rxd;
    logic        gmii_rx_dv;
    logic        user_tx_req;
    logic        user_tx_en;
    logic [7:0]  user_txd;
    logic        gmii_tx_en;
    logic [7:0]  gmii_txd;
    logic        user_tx_sel;
    logic        arp_working;
    logic        idle_chk;
    logic        exp_push;
    logic        exp_kind;
    logic [47:0] exp_mac;
    logic [31:0] exp_ip;
    logic        done_chk;
    int          frames_seen;
    int          chk_errors;
    int          tb_errors;
    int          expected_frames;
    int          gap;
    logic [15:0] lfsr;
    row_t        rows[N_ROWS];

    tb_clock tb_clock_i (
        .gmii_tx_clk (gmii_tx_clk),
        .rstn        (rstn)
    );

    arp_responder #(
        .BOARD_MAC (BOARD_MAC),
        .BOARD_IP  (BOARD_IP)
    ) arp_responder_i (
        .gmii_tx_clk (gmii_tx_clk),
        .rstn        (rstn),
        .gmii_rxd    (gmii_rxd),
        .gmii_rx_dv  (gmii_rx_dv),
        .user_tx_req (user_tx_req),
        .user_tx_en  (user_tx_en),
        .user_txd    (user_txd),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd),
        .user_tx_sel (user_tx_sel),
        .arp_working (arp_working)
    );

    arp_checker #(
        .BOARD_MAC (BOARD_MAC),
        .BOARD_IP  (BOARD_IP),
        .USER_LEN  (USER_LEN)
    ) arp_checker_i (
        .gmii_tx_clk (gmii_tx_clk),
        .rstn        (rstn),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd),
        .user_tx_sel (user_tx_sel),
        .arp_working (arp_working),
        .idle_chk    (idle_chk),
        .exp_push    (exp_push),
        .exp_kind    (exp_kind),
        .exp_mac     (exp_mac),
        .exp_ip      (exp_ip),
        .done_chk    (done_chk),
        .frames_seen (frames_seen),
        .err_count   (chk_errors)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic next_cycle();
        @(posedge gmii_tx_clk);
        #2;
    endtask

    task automatic expect_frame(input logic kind, input logic [47:0] mac, input logic [31:0] ip);
        exp_kind = kind;
        exp_mac  = mac;
        exp_ip   = ip;
        exp_push = 1'b1;
        next_cycle();
        exp_push = 1'b0;
        expected_frames++;
    endtask

    task automatic send_rx_frame(input row_t r);
        logic [575:0] f;
        f = {{7{eth_pkg::PREAMBLE_BYTE}}, eth_pkg::SFD_BYTE, r.dst, r.sha, r.etype,
             arp_pkg::HW_TYPE_ETH, arp_pkg::PROTO_TYPE_IPV4, arp_pkg::MAC_LEN,
             arp_pkg::IP_LEN, r.op, r.sha, r.spa, 48'h0, r.tpa, 144'h0, 32'h0};
        for (int i = 0; i < 72; i++) begin
            gmii_rx_dv = 1'b1;
            gmii_rxd   = f[8 * (71 - i) +: 8];
            next_cycle();
        end
        gmii_rx_dv = 1'b0;
        gmii_rxd   = 8'h00;
    endtask

    task automatic wait_user_sel();
        int n;
        n = 0;
        while (!user_tx_sel && n < 400) begin
            next_cycle();
            n++;
        end
        if (!user_tx_sel) begin
            $display("t=%0t user_tx_sel was never granted", $time);
            tb_errors++;
        end
    endtask

    task automatic send_user_burst(input logic [7:0] seed);
        for (int i = 0; i < USER_LEN; i++) begin
            user_tx_en = 1'b1;
            user_txd   = 8'(seed + i);
            next_cycle();
        end
        user_tx_en  = 1'b0;
        user_txd    = 8'h00;
        user_tx_req = 1'b0;
    endtask

    task automatic run_row(input int idx);
        row_t       r;
        logic [7:0] seed;
        int         n;
        r    = rows[idx];
        seed = 8'(idx * 16);
        if (r.overlap == 2'd1) begin
            user_tx_req = 1'b1;
            wait_user_sel();
            expect_frame(1'b1, 48'h0, {24'h0, seed});
        end
        if (r.reply) begin
            expect_frame(1'b0, r.sha, r.spa);
        end
        if (r.overlap == 2'd2) begin
            expect_frame(1'b1, 48'h0, {24'h0, seed});
        end
        send_rx_frame(r);
        if (r.overlap == 2'd1) begin
            send_user_burst(seed);
        end else if (r.overlap == 2'd2) begin
            repeat (3) next_cycle();    // arp_tx_req rises 3 cycles after dv falls
            user_tx_req = 1'b1;
            wait_user_sel();
            send_user_burst(seed);
        end
        n = 0;
        while (frames_seen < expected_frames && n < 600) begin
            next_cycle();
            n++;
        end
        if (frames_seen < expected_frames) begin
            $display("t=%0t row %0d: expected frame did not appear in time", $time, idx);
            tb_errors++;
        end
        if (!r.reply) begin
            repeat (150) next_cycle();  // room for a wrong reply to show up
        end
        random_bits(4, gap);
        repeat (4 + gap) next_cycle();
    endtask

    initial begin
        rows[0] = '{48'h00_1b_21_aa_01_01, 32'hc0_a8_00_10, BOARD_IP, arp_pkg::ARP_OP_REQ,
                    eth_pkg::ETH_TYPE_ARP, eth_pkg::BCAST_MAC, 1'b1, 2'd0};
        rows[1] = '{48'h00_1b_21_aa_02_02, 32'hc0_a8_00_11, BOARD_IP, arp_pkg::ARP_OP_REQ,
                    eth_pkg::ETH_TYPE_ARP, BOARD_MAC, 1'b1, 2'd0};
        rows[2] = '{48'h00_1b_21_aa_03_03, 32'hc0_a8_00_12, 32'hc0_a8_00_64,
                    arp_pkg::ARP_OP_REQ, eth_pkg::ETH_TYPE_ARP, eth_pkg::BCAST_MAC, 1'b0, 2'd0};
        rows[3] = '{48'h00_1b_21_aa_04_04, 32'hc0_a8_00_13, BOARD_IP, arp_pkg::ARP_OP_REP,
                    eth_pkg::ETH_TYPE_ARP, eth_pkg::BCAST_MAC, 1'b0, 2'd0};
        rows[4] = '{48'h00_1b_21_aa_05_05, 32'hc0_a8_00_14, BOARD_IP, arp_pkg::ARP_OP_REQ,
                    16'h0800, eth_pkg::BCAST_MAC, 1'b0, 2'd0};
        rows[5] = '{48'h00_1b_21_aa_06_06, 32'hc0_a8_00_15, BOARD_IP, arp_pkg::ARP_OP_REQ,
                    eth_pkg::ETH_TYPE_ARP, 48'h02_00_5e_10_20_31, 1'b0, 2'd0};
        rows[6] = '{48'h00_1b_21_aa_07_07, 32'hc0_a8_00_16, BOARD_IP, arp_pkg::ARP_OP_REQ,
                    eth_pkg::ETH_TYPE_ARP, eth_pkg::BCAST_MAC, 1'b1, 2'd1};
        rows[7] = '{48'h00_1b_21_aa_08_08, 32'hc0_a8_00_17, BOARD_IP, arp_pkg::ARP_OP_REQ,
                    eth_pkg::ETH_TYPE_ARP, eth_pkg::BCAST_MAC, 1'b1, 2'd2};
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        gmii_rxd        = 8'h00;
        gmii_rx_dv      = 1'b0;
        user_tx_req     = 1'b0;
        user_tx_en      = 1'b0;
        user_txd        = 8'h00;
        idle_chk        = 1'b0;
        exp_push        = 1'b0;
        exp_kind        = 1'b0;
        exp_mac         = 48'h0;
        exp_ip          = 32'h0;
        done_chk        = 1'b0;
        tb_errors       = 0;
        expected_frames = 0;
        lfsr            = 16'd6709;
        @(posedge rstn);
        next_cycle();
        idle_chk = 1'b1;
        repeat (10) next_cycle();
        idle_chk = 1'b0;
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        done_chk = 1'b1;
        next_cycle();
        done_chk = 1'b0;
        next_cycle();
        $display("errors: checker %0d, testbench %0d, frames seen %0d of %0d",
                 chk_errors, tb_errors, frames_seen, expected_frames);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
verilog/eth_pkg.sv
verilog/arp_pkg.sv
verilog/arp_rx_parser.sv
verilog/crc32_d8.sv
verilog/arp_tx.sv
verilog/gmii_tx_arbiter.sv
verilog/arp_responder.sv
bench/tb_clock.sv
bench/arp_checker.sv
bench/arp_responder_asserts.sv
bench/arp_responder_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the arp responder testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f project.f --top-module arp_responder_tb \
        --Mdir obj_dir -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
rc=$?
cat sim.log
if [ "$rc" -ne 0 ]; then
    echo "simulation exited with status $rc"
    exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
